/* common/cache_pkg.sv */
package cache_pkg;

    // 16 sets of 8-word lines, way count comes from the top level
    localparam int SETS = 16;
    localparam int LINE_WORDS = 8;

    localparam int ALIGN_W = 2;
    localparam int OFFSET_W = $clog2(LINE_WORDS);
    localparam int INDEX_W = $clog2(SETS);
    localparam int TAG_W = 32 - INDEX_W - OFFSET_W - ALIGN_W;

    typedef logic [ALIGN_W-1:0] align_t;
    typedef logic [OFFSET_W-1:0] offset_t;
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [TAG_W-1:0] tag_t;

    typedef struct packed {
        tag_t tag;
        index_t index;
        offset_t offset;
        align_t align;
    } addr_fields_t;

    // same address word, seen raw on the bus or split for lookup
    typedef union packed {
        logic [31:0] raw;
        addr_fields_t f;
    } cache_addr_u;

    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } line_meta_t;

endpackage

/* common/bus_pkg.sv */
package bus_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [3:0] strobe_t;

    // burst size in beats minus one
    typedef logic [3:0] len_t;

    // processor data port
    typedef struct packed {
        logic valid;
        addr_t addr;
        strobe_t strobe;
        word_t data;
    } dbus_req_t;

    typedef struct packed {
        logic addr_ok;
        logic data_ok;
        word_t data;
    } dbus_resp_t;

    // burst memory port
    typedef struct packed {
        logic valid;
        logic is_write;
        addr_t addr;
        word_t data;
        len_t len;
    } cbus_req_t;

    typedef struct packed {
        logic ready;
        logic last;
        word_t data;
    } cbus_resp_t;

endpackage

/* dcache/plru.sv */
module plru #(
    parameter int WAYS = 4,
    localparam int WAY_W = $clog2(WAYS)
) (
    input  logic               clk,
    input  logic               resetn,
    input  cache_pkg::index_t  index,
    input  logic               touch,
    input  logic [WAY_W-1:0]   touch_way,
    output logic [WAY_W-1:0]   victim_way
);

    typedef logic [WAYS-2:0] tree_t;

    tree_t tree_q [cache_pkg::SETS];
    tree_t bits;
    tree_t next_bits;

    assign bits = tree_q[index];

    // heap order, node n has children 2n and 2n+1, leaves start at WAYS
    always_comb begin
        int node;
        node = 1;
        for (int l = 0; l < WAY_W; l++) begin
            node = 2 * node + int'(bits[node-1]);
        end
        victim_way = WAY_W'(node - WAYS);
    end

    // point every node on the path away from the touched way
    always_comb begin
        int node;
        logic dir;
        next_bits = bits;
        node = 1;
        for (int l = 0; l < WAY_W; l++) begin
            dir = touch_way[WAY_W-1-l];
            next_bits[node-1] = ~dir;
            node = 2 * node + int'(dir);
        end
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            for (int s = 0; s < cache_pkg::SETS; s++) begin
                tree_q[s] <= '0;
            end
        end else if (touch) begin
            tree_q[index] <= next_bits;
        end
    end

endmodule

/* dcache/meta_store.sv */
module meta_store #(
    parameter int WAYS = 4,
    localparam int WAY_W = $clog2(WAYS)
) (
    input  logic                   clk,
    input  logic                   resetn,
    input  cache_pkg::index_t      index,
    input  logic                   we,
    input  logic [WAY_W-1:0]       way,
    input  cache_pkg::line_meta_t  wdata,
    input  logic                   set_dirty,
    input  cache_pkg::tag_t        tag,
    output logic                   hit,
    output logic [WAY_W-1:0]       hit_way,
    input  logic [WAY_W-1:0]       victim_way,
    output cache_pkg::line_meta_t  victim_meta
);

    cache_pkg::line_meta_t meta_q [cache_pkg::SETS][WAYS];
    logic [WAYS-1:0] hit_vec;

    // all ways of the set compared at once
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            hit_vec[w] = meta_q[index][w].valid && (meta_q[index][w].tag == tag);
            if (hit_vec[w]) begin
                hit_way = WAY_W'(w);
            end
        end
    end

    assign hit = |hit_vec;
    assign victim_meta = meta_q[index][victim_way];

    always_ff @(posedge clk) begin
        if (resetn) begin
            for (int s = 0; s < cache_pkg::SETS; s++) begin
                for (int w = 0; w < WAYS; w++) begin
                    meta_q[s][w].valid <= 1'b0;
                end
            end
        end else begin
            if (set_dirty && hit) begin
                meta_q[index][hit_way].dirty <= 1'b1;
            end
            // refill install
            if (we) begin
                meta_q[index][way] <= wdata;
            end
        end
    end

    // a tag may live in one way of a set only, across refills and hits
    a_one_hit: assert property (@(posedge clk) disable iff (resetn) $onehot0(hit_vec));

endmodule

/* dcache/dcache_ctrl.sv */
module dcache_ctrl #(
    parameter int WAYS = 4,
    localparam int WAY_W = $clog2(WAYS)
) (
    input  logic                   clk,
    input  logic                   resetn,
    input  bus_pkg::dbus_req_t     dreq,
    output bus_pkg::dbus_resp_t    dresp,
    output bus_pkg::cbus_req_t     creq,
    input  bus_pkg::cbus_resp_t    cresp,
    output cache_pkg::index_t      meta_index,
    output cache_pkg::tag_t        meta_tag,
    output logic                   set_dirty,
    input  logic                   hit,
    input  logic [WAY_W-1:0]       hit_way,
    input  logic [WAY_W-1:0]       victim_way,
    input  cache_pkg::line_meta_t  victim_meta,
    output logic                   meta_we,
    output logic [WAY_W-1:0]       meta_way,
    output cache_pkg::line_meta_t  meta_wdata,
    output logic                   touch,
    output logic [WAY_W-1:0]       touch_way,
    output logic                   ram_en,
    output bus_pkg::strobe_t       ram_strobe,
    output logic [WAY_W-1:0]       ram_way,
    output cache_pkg::index_t      ram_index,
    output cache_pkg::offset_t     ram_offset,
    output bus_pkg::word_t         ram_wdata,
    input  bus_pkg::word_t         ram_rdata
);

    typedef enum logic [1:0] {IDLE, WRITEBACK, REFILL} state_t;

    state_t state_q;
    cache_pkg::cache_addr_u req_addr;
    cache_pkg::cache_addr_u wb_addr;
    cache_pkg::cache_addr_u rf_addr;
    logic [WAY_W-1:0] vway_q;
    cache_pkg::tag_t vtag_q;
    cache_pkg::offset_t beat_q;
    logic primed_q;
    bus_pkg::word_t stage_q;
    logic data_ok_q;
    logic req_hit;
    logic req_miss;
    logic beat_ok;
    logic refill_done;

    assign req_addr.raw = dreq.addr;

    assign req_hit = (state_q == IDLE) && dreq.valid && hit;
    assign req_miss = (state_q == IDLE) && dreq.valid && !hit;
    assign beat_ok = creq.valid && cresp.ready;
    assign refill_done = (state_q == REFILL) && beat_ok && cresp.last;

    assign meta_index = req_addr.f.index;
    assign meta_tag = req_addr.f.tag;
    assign set_dirty = req_hit && (|dreq.strobe);

    assign dresp.addr_ok = req_hit;
    assign dresp.data_ok = data_ok_q;
    assign dresp.data = ram_rdata;

    // last refill beat installs the line clean
    assign meta_we = refill_done;
    assign meta_way = vway_q;
    assign meta_wdata = '{valid: 1'b1, dirty: 1'b0, tag: req_addr.f.tag};

    assign touch = req_hit || refill_done;
    assign touch_way = req_hit ? hit_way : vway_q;

    // burst addresses always start at word 0
    always_comb begin
        wb_addr.f.tag = vtag_q;
        wb_addr.f.index = req_addr.f.index;
        wb_addr.f.offset = '0;
        wb_addr.f.align = '0;
        rf_addr.f.tag = req_addr.f.tag;
        rf_addr.f.index = req_addr.f.index;
        rf_addr.f.offset = '0;
        rf_addr.f.align = '0;
    end

    assign creq.valid = ((state_q == WRITEBACK) && primed_q) || (state_q == REFILL);
    assign creq.is_write = (state_q == WRITEBACK);
    assign creq.addr = (state_q == WRITEBACK) ? wb_addr.raw : rf_addr.raw;
    assign creq.data = stage_q;
    assign creq.len = bus_pkg::len_t'(cache_pkg::LINE_WORDS - 1);

    assign ram_index = req_addr.f.index;

    always_comb begin
        ram_en = 1'b0;
        ram_strobe = '0;
        ram_way = hit_way;
        ram_offset = req_addr.f.offset;
        ram_wdata = dreq.data;
        unique case (state_q)
            IDLE: begin
                if (req_hit) begin
                    ram_en = 1'b1;
                    ram_strobe = dreq.strobe;
                end else if (req_miss) begin
                    // fetch victim word 0 early in case it needs writing back
                    ram_en = 1'b1;
                    ram_way = victim_way;
                    ram_offset = '0;
                end
            end
            WRITEBACK: begin
                // ram output runs one word ahead of the staging register
                ram_en = !primed_q || beat_ok;
                ram_way = vway_q;
                ram_offset = primed_q ? cache_pkg::offset_t'(beat_q + 3'd2)
                                      : cache_pkg::offset_t'(1);
            end
            REFILL: begin
                ram_en = beat_ok;
                ram_strobe = '1;
                ram_way = vway_q;
                ram_offset = beat_q;
                ram_wdata = cresp.data;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            state_q <= IDLE;
            data_ok_q <= 1'b0;
            primed_q <= 1'b0;
            beat_q <= '0;
        end else begin
            data_ok_q <= req_hit;
            unique case (state_q)
                IDLE: begin
                    if (req_miss) begin
                        beat_q <= '0;
                        primed_q <= 1'b0;
                        if (victim_meta.valid && victim_meta.dirty) begin
                            state_q <= WRITEBACK;
                        end else begin
                            state_q <= REFILL;
                        end
                    end
                end
                WRITEBACK: begin
                    if (!primed_q) begin
                        primed_q <= 1'b1;
                    end else if (beat_ok) begin
                        beat_q <= beat_q + 1'b1;
                        if (cresp.last) begin
                            state_q <= REFILL;
                            primed_q <= 1'b0;
                            beat_q <= '0;
                        end
                    end
                end
                REFILL: begin
                    if (beat_ok) begin
                        beat_q <= beat_q + 1'b1;
                        if (cresp.last) begin
                            state_q <= IDLE;
                        end
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // victim captured when the miss is seen
    always_ff @(posedge clk) begin
        if (req_miss) begin
            vway_q <= victim_way;
            vtag_q <= victim_meta.tag;
        end
        if ((state_q == WRITEBACK) && (!primed_q || beat_ok)) begin
            stage_q <= ram_rdata;
        end
    end

    a_creq_stable: assert property (@(posedge clk) disable iff (resetn)
        creq.valid && !cresp.ready |=> creq.valid && $stable(creq.addr)
            && $stable(creq.is_write) && $stable(creq.data));

endmodule

/* hw/data_ram.sv */
module data_ram #(
    parameter int WAYS = 4,
    localparam int WAY_W = $clog2(WAYS)
) (
    input  logic                clk,
    input  logic                en,
    input  bus_pkg::strobe_t    strobe,
    input  logic [WAY_W-1:0]    way,
    input  cache_pkg::index_t   index,
    input  cache_pkg::offset_t  offset,
    input  bus_pkg::word_t      wdata,
    output bus_pkg::word_t      rdata
);

    localparam int DEPTH = WAYS * cache_pkg::SETS * cache_pkg::LINE_WORDS;

    bus_pkg::word_t mem [DEPTH];
    logic [$clog2(DEPTH)-1:0] addr;

    assign addr = {way, index, offset};

    // read-first, rdata shows the word before this cycle's write
    always_ff @(posedge clk) begin
        if (en) begin
            rdata <= mem[addr];
            for (int b = 0; b < $bits(bus_pkg::strobe_t); b++) begin
                if (strobe[b]) begin
                    mem[addr][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

/* hw/dcache_top.sv */
module dcache_top #(
    parameter int WAYS = 4,
    localparam int WAY_W = $clog2(WAYS)
) (
    input  logic                 clk,
    input  logic                 resetn,
    input  bus_pkg::dbus_req_t   dreq,
    output bus_pkg::dbus_resp_t  dresp,
    output bus_pkg::cbus_req_t   creq,
    input  bus_pkg::cbus_resp_t  cresp
);

    cache_pkg::index_t meta_index;
    cache_pkg::tag_t meta_tag;
    logic set_dirty;
    logic hit;
    logic [WAY_W-1:0] hit_way;
    logic [WAY_W-1:0] victim_way;
    cache_pkg::line_meta_t victim_meta;
    logic meta_we;
    logic [WAY_W-1:0] meta_way;
    cache_pkg::line_meta_t meta_wdata;
    logic touch;
    logic [WAY_W-1:0] touch_way;
    logic ram_en;
    bus_pkg::strobe_t ram_strobe;
    logic [WAY_W-1:0] ram_way;
    cache_pkg::index_t ram_index;
    cache_pkg::offset_t ram_offset;
    bus_pkg::word_t ram_wdata;
    bus_pkg::word_t ram_rdata;

    dcache_ctrl #(.WAYS(WAYS)) i_ctrl (
        .clk, .resetn, .dreq, .dresp, .creq, .cresp,
        .meta_index, .meta_tag, .set_dirty,
        .hit, .hit_way, .victim_way, .victim_meta,
        .meta_we, .meta_way, .meta_wdata,
        .touch, .touch_way,
        .ram_en, .ram_strobe, .ram_way, .ram_index, .ram_offset,
        .ram_wdata, .ram_rdata
    );

    meta_store #(.WAYS(WAYS)) i_meta (
        .clk, .resetn,
        .index(meta_index),
        .we(meta_we),
        .way(meta_way),
        .wdata(meta_wdata),
        .set_dirty,
        .tag(meta_tag),
        .hit,
        .hit_way,
        .victim_way,
        .victim_meta
    );

    plru #(.WAYS(WAYS)) i_plru (
        .clk, .resetn,
        .index(meta_index),
        .touch,
        .touch_way,
        .victim_way
    );

    data_ram #(.WAYS(WAYS)) i_data (
        .clk,
        .en(ram_en),
        .strobe(ram_strobe),
        .way(ram_way),
        .index(ram_index),
        .offset(ram_offset),
        .wdata(ram_wdata),
        .rdata(ram_rdata)
    );

endmodule

/* tests/tb_clock.sv */
module tb_clock #(
    parameter int PERIOD = 100,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic resetn
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // reset is active high, released just after a rising edge
    initial begin
        resetn = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        resetn = 1'b0;
    end

endmodule

/* tests/tb_dcache.sv */
module tb_dcache;

    localparam int WAYS = 4;
    localparam int LEVELS = $clog2(WAYS);
    localparam int NUM_OPS = 2000;
    localparam int TIMEOUT = NUM_OPS * 40;
    localparam int LINE = cache_pkg::LINE_WORDS;
    // eight tags against four ways keeps evictions frequent
    localparam int MEM_WORDS = 8 * cache_pkg::SETS * LINE;

    logic clk;
    logic resetn;
    bus_pkg::dbus_req_t dreq;
    bus_pkg::dbus_resp_t dresp;
    bus_pkg::cbus_req_t creq;
    bus_pkg::cbus_resp_t cresp;

    bus_pkg::word_t model_mem [MEM_WORDS];
    bus_pkg::word_t resp_mem [MEM_WORDS];
    logic model_valid [cache_pkg::SETS][WAYS];
    logic model_dirty [cache_pkg::SETS][WAYS];
    cache_pkg::tag_t model_tag [cache_pkg::SETS][WAYS];
    logic [WAYS-2:0] model_plru [cache_pkg::SETS];

    // bursts the model expects, oldest first
    logic exp_write [$];
    logic [31:0] exp_addr [$];

    logic [31:0] rand_state;
    int cycles;
    int ops_issued;
    int ops_done;
    logic first_cycle;
    logic predicted_hit;
    logic pend_data_ok;
    logic pend_read;
    bus_pkg::word_t pend_data;
    bus_pkg::dbus_req_t next_dreq;
    logic burst_active;
    logic burst_write;
    logic [31:0] burst_addr;
    int beat;
    logic stalled;
    bus_pkg::word_t stall_data;

    tb_clock i_clock (.clk, .resetn);

    dcache_top #(.WAYS(WAYS)) i_dcache_top (
        .clk, .resetn, .dreq, .dresp, .creq, .cresp
    );

    function automatic logic [31:0] lcg_next();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    function automatic bus_pkg::word_t init_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
    endfunction

    function automatic int word_index(input logic [31:0] addr);
        return int'(addr[11:2]);
    endfunction

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("FAIL %0t: %s, got %h expected %h", $time, what, got, exp);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    // tree bits in heap order, a set bit steers the walk to the upper half
    function automatic int plru_victim(input int set);
        int node;
        node = 0;
        for (int l = 0; l < LEVELS; l++) begin
            node = 2 * node + 1 + int'(model_plru[set][node]);
        end
        return node - (WAYS - 1);
    endfunction

    task automatic plru_touch(input int set, input int way);
        int node;
        int dir;
        node = 0;
        for (int l = LEVELS - 1; l >= 0; l--) begin
            dir = (way >> l) & 1;
            model_plru[set][node] = (dir == 0);
            node = 2 * node + 1 + dir;
        end
    endtask

    task automatic predict_access(input logic [31:0] addr, input logic is_write,
                                  output logic hit);
        int set;
        int way;
        set = int'(addr[8:5]);
        hit = 1'b0;
        way = 0;
        for (int w = 0; w < WAYS; w++) begin
            if (model_valid[set][w] && model_tag[set][w] == addr[31:9]) begin
                hit = 1'b1;
                way = w;
            end
        end
        if (!hit) begin
            way = plru_victim(set);
            if (model_valid[set][way] && model_dirty[set][way]) begin
                exp_write.push_back(1'b1);
                exp_addr.push_back({model_tag[set][way], addr[8:5], 5'b0});
            end
            exp_write.push_back(1'b0);
            exp_addr.push_back({addr[31:5], 5'b0});
            model_valid[set][way] = 1'b1;
            model_dirty[set][way] = 1'b0;
            model_tag[set][way] = addr[31:9];
            plru_touch(set, way);
        end
        // the retried request hits the same way
        plru_touch(set, way);
        if (is_write) begin
            model_dirty[set][way] = 1'b1;
        end
    endtask

    task automatic make_op();
        logic [31:0] r;
        logic hit;
        r = lcg_next();
        next_dreq.valid = 1'b1;
        next_dreq.addr = {20'b0, r[25:16], 2'b00};
        next_dreq.strobe = r[31] ? r[29:26] : 4'h0;
        if (r[31] && r[29:26] == 4'h0) begin
            next_dreq.strobe = 4'hf;
        end
        next_dreq.data = lcg_next();
        predict_access(next_dreq.addr, |next_dreq.strobe, hit);
        predicted_hit = hit;
        first_cycle = 1'b1;
        ops_issued++;
    endtask

    task automatic check_idle();
        check_eq(32'(dresp.addr_ok), 32'd0, "addr_ok after reset");
        check_eq(32'(dresp.data_ok), 32'd0, "data_ok after reset");
        check_eq(32'(creq.valid), 32'd0, "creq.valid after reset");
    endtask

    task automatic track_burst();
        int idx;
        if (!burst_active && creq.valid) begin
            check_eq(32'(exp_write.size() != 0), 32'd1, "burst without a predicted miss");
            check_eq(32'(creq.is_write), 32'(exp_write.pop_front()), "burst direction");
            check_eq(creq.addr, exp_addr.pop_front(), "burst address");
            check_eq(32'(creq.len), 32'(LINE - 1), "burst length");
            burst_active = 1'b1;
            burst_write = creq.is_write;
            burst_addr = creq.addr;
            beat = 0;
            stalled = 1'b0;
        end else if (burst_active) begin
            check_eq(32'(creq.valid), 32'd1, "valid dropped inside burst");
            check_eq(creq.addr, burst_addr, "burst address changed");
            check_eq(32'(creq.is_write), 32'(burst_write), "burst direction changed");
            if (burst_write && stalled) begin
                check_eq(creq.data, stall_data, "write data changed while stalled");
            end
        end
        if (burst_active) begin
            idx = word_index(burst_addr) + beat;
            if (cresp.ready) begin
                if (burst_write) begin
                    check_eq(creq.data, model_mem[idx], "writeback data");
                    resp_mem[idx] = creq.data;
                end
                stalled = 1'b0;
                if (beat == LINE - 1) begin
                    burst_active = 1'b0;
                end
                beat++;
            end else begin
                stalled = 1'b1;
                stall_data = creq.data;
            end
        end
    endtask

    // outputs are read at the falling edge, where they are settled
    task automatic sample_cycle();
        logic accepted;
        logic [31:0] r;
        int idx;
        accepted = 1'b0;
        check_eq(32'(dresp.data_ok), 32'(pend_data_ok), "data_ok timing");
        if (pend_data_ok && pend_read) begin
            check_eq(dresp.data, pend_data, "read data");
        end
        pend_data_ok = 1'b0;
        track_burst();
        if (dreq.valid) begin
            if (first_cycle) begin
                check_eq(32'(dresp.addr_ok), 32'(predicted_hit), "hit or miss prediction");
            end
            first_cycle = 1'b0;
            if (dresp.addr_ok) begin
                check_eq(32'(exp_write.size()), 32'd0, "addr_ok before expected bursts");
                check_eq(32'(burst_active), 32'd0, "addr_ok inside a burst");
                idx = word_index(dreq.addr);
                pend_read = (dreq.strobe == 4'h0);
                pend_data = model_mem[idx];
                for (int b = 0; b < 4; b++) begin
                    if (dreq.strobe[b]) begin
                        model_mem[idx][8*b +: 8] = dreq.data[8*b +: 8];
                    end
                end
                pend_data_ok = 1'b1;
                accepted = 1'b1;
                ops_done++;
            end
        end else begin
            check_eq(32'(dresp.addr_ok), 32'd0, "addr_ok without request");
        end
        r = lcg_next();
        if (dreq.valid && !accepted) begin
            next_dreq = dreq;
        end else if (ops_issued < NUM_OPS && r[31:30] != 2'b00) begin
            make_op();
        end else begin
            next_dreq = '0;
        end
    endtask

    task automatic drive_inputs();
        logic [31:0] r;
        dreq = next_dreq;
        r = lcg_next();
        cresp = '0;
        if (burst_active && r[31:30] != 2'b00) begin
            cresp.ready = 1'b1;
            cresp.last = (beat == LINE - 1);
            if (!burst_write) begin
                cresp.data = resp_mem[word_index(burst_addr) + beat];
            end
        end
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT);
            $display("Verification failed");
            $fatal(1);
        end
    end

    initial begin
        dreq = '0;
        cresp = '0;
        next_dreq = '0;
        rand_state = 32'd57280;
        cycles = 0;
        ops_issued = 0;
        ops_done = 0;
        first_cycle = 1'b0;
        predicted_hit = 1'b0;
        pend_data_ok = 1'b0;
        pend_read = 1'b0;
        pend_data = '0;
        burst_active = 1'b0;
        burst_write = 1'b0;
        burst_addr = '0;
        beat = 0;
        stalled = 1'b0;
        stall_data = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            model_mem[i] = init_word(32'(i) << 2);
            resp_mem[i] = init_word(32'(i) << 2);
        end
        for (int s = 0; s < cache_pkg::SETS; s++) begin
            model_plru[s] = '0;
            for (int w = 0; w < WAYS; w++) begin
                model_valid[s][w] = 1'b0;
                model_dirty[s][w] = 1'b0;
                model_tag[s][w] = '0;
            end
        end

        @(posedge clk);
        while (resetn) begin
            @(negedge clk);
            check_idle();
        end
        repeat (3) begin
            @(negedge clk);
            check_idle();
        end

        while (ops_done < NUM_OPS || pend_data_ok || burst_active) begin
            @(negedge clk);
            sample_cycle();
            @(posedge clk);
            #1;
            drive_inputs();
        end
        check_eq(32'(exp_write.size()), 32'd0, "bursts left over at end");
        $display("Verification passed");
        $finish;
    end

endmodule

/* build.f */
common/cache_pkg.sv
common/bus_pkg.sv
dcache/plru.sv
dcache/meta_store.sv
dcache/dcache_ctrl.sv
hw/data_ram.sv
hw/dcache_top.sv
tests/tb_clock.sv
tests/tb_dcache.sv

/* run_sim.sh */
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_dcache -f build.f \
    --Mdir "$BUILD_DIR" -o sim_dcache
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

"$BUILD_DIR/sim_dcache" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
fi

if grep -q "^Verification passed$" "$LOG"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi
